/* verilog/fe_cfg_pkg.sv */
// front end sizes for RV32I only; sram word must be exactly two instructions wide
package fe_cfg_pkg;

  // instruction and pc
  localparam int INST_WD      = 32;
  localparam int PC_WD        = 32;

  // decoded fields
  localparam int REG_IDX_WD   = 5;   // x0..x31
  localparam int IMM_WD       = 32;  // sign-extended immediate

  // instruction sram
  localparam int SRAM_ADDR_WD = 32;  // byte address
  localparam int SRAM_DATA_WD = 64;  // two instructions per read

endpackage

/* verilog/fe_types_pkg.sv */
// bus layouts between fetch, decode and the outside; widths come from fe_cfg_pkg
package fe_types_pkg;

  // opcode class of one instruction
  typedef enum logic [3:0] {
    OP_ALU,
    OP_ALU_IMM,
    OP_LOAD,
    OP_STORE,
    OP_BRANCH,
    OP_JAL,
    OP_JALR,
    OP_LUI,
    OP_AUIPC,
    OP_SYSTEM,
    OP_ILLEGAL
  } op_class_e;

  // redirect from decode back to fetch
  typedef struct packed {
    logic                            taken;
    logic [fe_cfg_pkg::PC_WD-1:0]    target;
  } br_bus_t;

  // fetched instruction with its pc
  typedef struct packed {
    logic [fe_cfg_pkg::INST_WD-1:0]  inst;
    logic [fe_cfg_pkg::PC_WD-1:0]    pc;
  } fs_to_ds_t;

  // decoded instruction leaving the front end
  typedef struct packed {
    logic [fe_cfg_pkg::PC_WD-1:0]      pc;
    logic [fe_cfg_pkg::INST_WD-1:0]    inst;
    op_class_e                         op_class;
    logic [fe_cfg_pkg::REG_IDX_WD-1:0] rd;
    logic [fe_cfg_pkg::REG_IDX_WD-1:0] rs1;
    logic [fe_cfg_pkg::REG_IDX_WD-1:0] rs2;
    logic [fe_cfg_pkg::IMM_WD-1:0]     imm;
  } ds_out_t;

endpackage

/* verilog/pc_gen.sv */
// PC_RESET_VAL must be word aligned; pc resets one word below it so the first load fetches it
`timescale 1ns/100ps

module pc_gen #(
  parameter logic [fe_cfg_pkg::PC_WD-1:0] PC_RESET_VAL = 32'h8000_0000
) (
  input  logic                                i_clk,
  input  logic                                i_rst_n,
  input  logic                                i_load,
  input  fe_types_pkg::br_bus_t               i_br,
  output logic [fe_cfg_pkg::PC_WD-1:0]        o_pc,
  output logic                                o_inst_sram_ren,
  output logic [fe_cfg_pkg::SRAM_ADDR_WD-1:0] o_inst_sram_addr
);

  logic [fe_cfg_pkg::PC_WD-1:0] pc_q;
  logic [fe_cfg_pkg::PC_WD-1:0] seq_pc;
  logic [fe_cfg_pkg::PC_WD-1:0] next_pc;
  logic [fe_cfg_pkg::PC_WD-1:0] addr_pc;

  assign seq_pc  = pc_q + fe_cfg_pkg::PC_WD'(4);
  assign next_pc = i_br.taken ? i_br.target : seq_pc;  // decode redirect wins

  // on hold the same word is read again, so rdata stays valid
  assign addr_pc = i_load ? next_pc : pc_q;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      pc_q <= PC_RESET_VAL - fe_cfg_pkg::PC_WD'(4);
    end else if (i_load) begin
      pc_q <= next_pc;
    end
  end

  assign o_pc             = pc_q;
  assign o_inst_sram_ren  = 1'b1;  // read every cycle, hold re-reads
  assign o_inst_sram_addr = addr_pc[fe_cfg_pkg::SRAM_ADDR_WD-1:0];

endmodule

/* verilog/if_stage.sv */
// fetch finishes in one cycle; sram data is expected one cycle after the address
`timescale 1ns/100ps

module if_stage #(
  parameter logic [fe_cfg_pkg::PC_WD-1:0] PC_RESET_VAL = 32'h8000_0000
) (
  input  logic                                i_clk,
  input  logic                                i_rst_n,
  // allowin from decode
  input  logic                                i_ds_allowin,
  // redirect from decode
  input  fe_types_pkg::br_bus_t               i_br,
  // to decode
  output logic                                o_fs_valid,
  output fe_types_pkg::fs_to_ds_t             o_fs_to_ds,
  // instruction sram
  output logic                                o_inst_sram_ren,
  output logic [fe_cfg_pkg::SRAM_ADDR_WD-1:0] o_inst_sram_addr,
  input  logic [fe_cfg_pkg::SRAM_DATA_WD-1:0] i_inst_sram_rdata
);

  logic                           fs_valid;
  logic                           fs_allowin;
  logic                           fs_load;
  logic [fe_cfg_pkg::INST_WD-1:0] fs_inst;

  // empty stage, or the held entry leaves this cycle
  assign fs_allowin  = !fs_valid || i_ds_allowin;
  assign fs_load     = fs_allowin;  // pre-fetch always has a pc ready

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      fs_valid <= 1'b0;
    end else if (fs_allowin) begin
      fs_valid <= 1'b1;
    end
  end

  pc_gen #(
    .PC_RESET_VAL     (PC_RESET_VAL)
  ) u_pc_gen (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_load           (fs_load),
    .i_br             (i_br),
    .o_pc             (o_fs_to_ds.pc),
    .o_inst_sram_ren  (o_inst_sram_ren),
    .o_inst_sram_addr (o_inst_sram_addr)
  );

  // sram word is 64-bit aligned, pc[2] picks the half
  assign fs_inst = o_fs_to_ds.pc[2] ?
                   i_inst_sram_rdata[fe_cfg_pkg::SRAM_DATA_WD-1 -: fe_cfg_pkg::INST_WD] :
                   i_inst_sram_rdata[fe_cfg_pkg::INST_WD-1:0];

  assign o_fs_to_ds.inst = fs_inst;
  assign o_fs_valid      = fs_valid;

endmodule

/* verilog/inst_decode.sv */
// RV32I base opcodes only, no compressed; unknown major opcodes decode as OP_ILLEGAL
`timescale 1ns/100ps

module inst_decode (
  input  logic [fe_cfg_pkg::INST_WD-1:0] i_inst,
  input  logic [fe_cfg_pkg::PC_WD-1:0]   i_pc,
  output fe_types_pkg::ds_out_t          o_dec
);

  // major opcode, bits [6:0]
  typedef enum logic [6:0] {
    MJ_LOAD   = 7'b000_0011,
    MJ_OP_IMM = 7'b001_0011,
    MJ_AUIPC  = 7'b001_0111,
    MJ_STORE  = 7'b010_0011,
    MJ_OP     = 7'b011_0011,
    MJ_LUI    = 7'b011_0111,
    MJ_BRANCH = 7'b110_0011,
    MJ_JALR   = 7'b110_0111,
    MJ_JAL    = 7'b110_1111,
    MJ_SYSTEM = 7'b111_0011
  } major_op_e;

  major_op_e                       opcode;
  fe_types_pkg::op_class_e         op_class;
  logic [fe_cfg_pkg::IMM_WD-1:0]   imm_i;
  logic [fe_cfg_pkg::IMM_WD-1:0]   imm_s;
  logic [fe_cfg_pkg::IMM_WD-1:0]   imm_b;
  logic [fe_cfg_pkg::IMM_WD-1:0]   imm_u;
  logic [fe_cfg_pkg::IMM_WD-1:0]   imm_j;
  logic [fe_cfg_pkg::IMM_WD-1:0]   imm;

  assign opcode = major_op_e'(i_inst[6:0]);

  always_comb begin
    case (opcode)
      MJ_OP:     op_class = fe_types_pkg::OP_ALU;
      MJ_OP_IMM: op_class = fe_types_pkg::OP_ALU_IMM;
      MJ_LOAD:   op_class = fe_types_pkg::OP_LOAD;
      MJ_STORE:  op_class = fe_types_pkg::OP_STORE;
      MJ_BRANCH: op_class = fe_types_pkg::OP_BRANCH;
      MJ_JAL:    op_class = fe_types_pkg::OP_JAL;
      MJ_JALR:   op_class = fe_types_pkg::OP_JALR;
      MJ_LUI:    op_class = fe_types_pkg::OP_LUI;
      MJ_AUIPC:  op_class = fe_types_pkg::OP_AUIPC;
      MJ_SYSTEM: op_class = fe_types_pkg::OP_SYSTEM;
      default:   op_class = fe_types_pkg::OP_ILLEGAL;
    endcase
  end

  // immediate formats, all sign-extended from bit 31
  assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{19{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_u = {i_inst[31:12], 12'b0};
  assign imm_j = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  always_comb begin
    case (op_class)
      fe_types_pkg::OP_ALU_IMM,
      fe_types_pkg::OP_LOAD,
      fe_types_pkg::OP_JALR,
      fe_types_pkg::OP_SYSTEM: imm = imm_i;
      fe_types_pkg::OP_STORE:  imm = imm_s;
      fe_types_pkg::OP_BRANCH: imm = imm_b;
      fe_types_pkg::OP_LUI,
      fe_types_pkg::OP_AUIPC:  imm = imm_u;
      fe_types_pkg::OP_JAL:    imm = imm_j;
      default:                 imm = '0;  // R-type and illegal
    endcase
  end

  assign o_dec.pc       = i_pc;
  assign o_dec.inst     = i_inst;
  assign o_dec.op_class = op_class;
  assign o_dec.rd       = i_inst[11:7];
  assign o_dec.rs1      = i_inst[19:15];
  assign o_dec.rs2      = i_inst[24:20];
  assign o_dec.imm      = imm;

endmodule

/* verilog/id_stage.sv */
// only JAL redirects here; the entry arriving with a taken redirect is dropped, one bubble per JAL
`timescale 1ns/100ps

module id_stage (
  input  logic                    i_clk,
  input  logic                    i_rst_n,
  // from fetch
  input  logic                    i_fs_valid,
  input  fe_types_pkg::fs_to_ds_t i_fs_to_ds,
  output logic                    o_ds_allowin,
  // redirect to fetch
  output fe_types_pkg::br_bus_t   o_br,
  // to the outside
  input  logic                    i_out_allowin,
  output logic                    o_out_valid,
  output fe_types_pkg::ds_out_t   o_out
);

  logic                    ds_valid;
  logic                    ds_allowin;
  logic                    ds_leave;
  logic                    br_taken;
  logic                    is_jal;
  fe_types_pkg::fs_to_ds_t ds_q;
  fe_types_pkg::ds_out_t   dec;

  assign ds_allowin  = !ds_valid || i_out_allowin;
  assign ds_leave    = ds_valid && i_out_allowin;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      ds_valid <= 1'b0;
    end else if (ds_allowin) begin
      ds_valid <= i_fs_valid && !br_taken;  // kill the wrong-path slot
    end
  end

  // payload, no reset
  always_ff @(posedge i_clk) begin
    if (i_fs_valid && ds_allowin) begin
      ds_q <= i_fs_to_ds;
    end
  end

  inst_decode u_inst_decode (
    .i_inst (ds_q.inst),
    .i_pc   (ds_q.pc),
    .o_dec  (dec)
  );

  assign is_jal   = dec.op_class == fe_types_pkg::OP_JAL;
  assign br_taken = ds_leave && is_jal;  // redirect only as the JAL leaves

  assign o_br.taken  = br_taken;
  assign o_br.target = dec.pc + dec.imm[fe_cfg_pkg::PC_WD-1:0];

  assign o_ds_allowin = ds_allowin;
  assign o_out_valid  = ds_valid;
  assign o_out        = dec;

endmodule

/* verilog/frontend_top.sv */
// fetch and decode only; expects a synchronous 64-bit sram with one cycle read latency
`timescale 1ns/100ps

module frontend_top #(
  parameter logic [fe_cfg_pkg::PC_WD-1:0] PC_RESET_VAL = 32'h8000_0000
) (
  input  logic                                i_clk,
  input  logic                                i_rst_n,
  // decoded output
  input  logic                                i_out_allowin,
  output logic                                o_out_valid,
  output fe_types_pkg::ds_out_t               o_out,
  // instruction sram
  output logic                                o_inst_sram_ren,
  output logic [fe_cfg_pkg::SRAM_ADDR_WD-1:0] o_inst_sram_addr,
  input  logic [fe_cfg_pkg::SRAM_DATA_WD-1:0] i_inst_sram_rdata
);

  logic                    fs_valid;
  logic                    ds_allowin;
  fe_types_pkg::fs_to_ds_t fs_to_ds;
  fe_types_pkg::br_bus_t   br;

  if_stage #(
    .PC_RESET_VAL      (PC_RESET_VAL)
  ) u_if_stage (
    .i_clk             (i_clk),
    .i_rst_n           (i_rst_n),
    .i_ds_allowin      (ds_allowin),
    .i_br              (br),
    .o_fs_valid        (fs_valid),
    .o_fs_to_ds        (fs_to_ds),
    .o_inst_sram_ren   (o_inst_sram_ren),
    .o_inst_sram_addr  (o_inst_sram_addr),
    .i_inst_sram_rdata (i_inst_sram_rdata)
  );

  id_stage u_id_stage (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_fs_valid    (fs_valid),
    .i_fs_to_ds    (fs_to_ds),
    .o_ds_allowin  (ds_allowin),
    .o_br          (br),
    .i_out_allowin (i_out_allowin),
    .o_out_valid   (o_out_valid),
    .o_out         (o_out)
  );

endmodule

/* verif/frontend_props.sv */
// port rules of frontend_top, bound to every instance; failures are also counted in fail_cnt
`timescale 1ns/100ps

module frontend_props (
  input logic                                i_clk,
  input logic                                i_rst_n,
  input logic                                i_out_allowin,
  input logic                                i_out_valid,
  input fe_types_pkg::ds_out_t               i_out,
  input logic                                i_sram_ren,
  input logic [fe_cfg_pkg::SRAM_ADDR_WD-1:0] i_sram_addr
);

  int unsigned fail_cnt = 0;

  // no output after a reset cycle
  a_valid_in_reset: assert property (@(posedge i_clk) !i_rst_n |=> !i_out_valid)
    else begin
      $error("o_out_valid high after a cycle in reset");
      fail_cnt++;
    end

  // held entry keeps its data
  a_out_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_out_valid && !i_out_allowin |=> i_out_valid && $stable(i_out))
    else begin
      $error("o_out changed or dropped while not accepted");
      fail_cnt++;
    end

  a_ren_high: assert property (@(posedge i_clk) i_rst_n |-> i_sram_ren)
    else begin
      $error("o_inst_sram_ren low out of reset");
      fail_cnt++;
    end

  a_addr_aligned: assert property (@(posedge i_clk) i_rst_n |-> i_sram_addr[1:0] == 2'b00)
    else begin
      $error("o_inst_sram_addr not word aligned");
      fail_cnt++;
    end

endmodule

bind frontend_top frontend_props u_props (
  .i_clk         (i_clk),
  .i_rst_n       (i_rst_n),
  .i_out_allowin (i_out_allowin),
  .i_out_valid   (o_out_valid),
  .i_out         (o_out),
  .i_sram_ren    (o_inst_sram_ren),
  .i_sram_addr   (o_inst_sram_addr)
);

/* verif/tb_frontend.sv */
// program must sit within 256 bytes of RESET_PC; sram model answers one cycle after each read
`timescale 1ns/100ps

module tb_frontend;

  localparam logic [31:0] RESET_PC   = 32'h8000_0000;
  localparam int          N_ROWS     = 15;
  localparam int          CLK_PERIOD = 10;
  localparam int          WD_CYCLES  = N_ROWS * 8 + 100;
  localparam logic [31:0] SEED       = 32'hd97c;

  // one program word and its expected decode
  typedef struct packed {
    logic [7:0]              off;  // pc offset from RESET_PC
    logic [31:0]             inst;
    fe_types_pkg::op_class_e cls;
    logic [4:0]              rd;
    logic [4:0]              rs1;
    logic [4:0]              rs2;
    logic [31:0]             imm;
    logic [7:0]              nxt;  // offset of the next pc on the path
  } row_t;

  logic                                i_clk;
  logic                                i_rst_n;
  logic                                i_out_allowin;
  logic                                o_out_valid;
  fe_types_pkg::ds_out_t               o_out;
  logic                                o_inst_sram_ren;
  logic [fe_cfg_pkg::SRAM_ADDR_WD-1:0] o_inst_sram_addr;
  logic [fe_cfg_pkg::SRAM_DATA_WD-1:0] i_inst_sram_rdata;

  row_t                  prog [N_ROWS];
  int                    exp_q [$];
  int                    idx;
  logic                  held;
  fe_types_pkg::ds_out_t held_out;

  frontend_top #(
    .PC_RESET_VAL      (RESET_PC)
  ) dut (
    .i_clk             (i_clk),
    .i_rst_n           (i_rst_n),
    .i_out_allowin     (i_out_allowin),
    .o_out_valid       (o_out_valid),
    .o_out             (o_out),
    .o_inst_sram_ren   (o_inst_sram_ren),
    .o_inst_sram_addr  (o_inst_sram_addr),
    .i_inst_sram_rdata (i_inst_sram_rdata)
  );

  initial begin
    i_clk = 1'b0;
    forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
  end

  function automatic int find_row(logic [31:0] pc);
    int hit;
    hit = -1;
    for (int i = 0; i < N_ROWS; i++) begin
      if (RESET_PC + 32'(prog[i].off) == pc) hit = i;
    end
    return hit;
  endfunction

  // table word, else a pattern tied to the full address
  function automatic logic [31:0] inst_at(logic [31:0] pc);
    int r;
    r = find_row(pc);
    return (r >= 0) ? prog[r].inst : (pc ^ 32'h5a5a_a5a5);
  endfunction

  always @(posedge i_clk) begin
    if (o_inst_sram_ren) begin
      i_inst_sram_rdata <= {inst_at({o_inst_sram_addr[31:3], 3'b100}),
                            inst_at({o_inst_sram_addr[31:3], 3'b000})};
    end
  end

  task automatic check(string name, logic [127:0] act, logic [127:0] exp);
    if (act !== exp) begin
      $display("ERROR %s: got %h, expected %h", name, act, exp);
      $display("tests failed");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  task automatic compare_out(int r);
    check("o_out.pc", o_out.pc, RESET_PC + 32'(prog[r].off));
    check("o_out.inst", o_out.inst, prog[r].inst);
    check("o_out.op_class", o_out.op_class, prog[r].cls);
    check("o_out.rd", o_out.rd, prog[r].rd);
    check("o_out.rs1", o_out.rs1, prog[r].rs1);
    check("o_out.rs2", o_out.rs2, prog[r].rs2);
    check("o_out.imm", o_out.imm, prog[r].imm);
  endtask

  task automatic load_program();
    // off, inst, class, rd, rs1, rs2, imm, next off
    prog[0]  = '{8'h00, 32'h00500093, fe_types_pkg::OP_ALU_IMM, 1, 0, 5, 32'h5, 8'h04};
    prog[1]  = '{8'h04, 32'h002081b3, fe_types_pkg::OP_ALU, 3, 1, 2, 32'h0, 8'h08};
    prog[2]  = '{8'h08, 32'hffc12283, fe_types_pkg::OP_LOAD, 5, 2, 28, 32'hfffffffc, 8'h0c};
    prog[3]  = '{8'h0c, 32'h00612423, fe_types_pkg::OP_STORE, 8, 2, 6, 32'h8, 8'h10};
    prog[4]  = '{8'h10, 32'hfe208ce3, fe_types_pkg::OP_BRANCH, 25, 1, 2, 32'hfffffff8, 8'h14};
    prog[5]  = '{8'h14, 32'h123453b7, fe_types_pkg::OP_LUI, 7, 8, 3, 32'h12345000, 8'h18};
    prog[6]  = '{8'h18, 32'hfffff417, fe_types_pkg::OP_AUIPC, 8, 31, 31, 32'hfffff000, 8'h1c};
    prog[7]  = '{8'h1c, 32'h010000ef, fe_types_pkg::OP_JAL, 1, 0, 16, 32'h10, 8'h2c};
    prog[8]  = '{8'h20, 32'h00100493, fe_types_pkg::OP_ALU_IMM, 9, 0, 1, 32'h1, 8'h24};  // shadow
    prog[9]  = '{8'h2c, 32'h00000073, fe_types_pkg::OP_SYSTEM, 0, 0, 0, 32'h0, 8'h30};
    prog[10] = '{8'h30, 32'hffffffff, fe_types_pkg::OP_ILLEGAL, 31, 31, 31, 32'h0, 8'h34};
    prog[11] = '{8'h34, 32'hffe08167, fe_types_pkg::OP_JALR, 2, 1, 30, 32'hfffffffe, 8'h38};
    prog[12] = '{8'h38, 32'h0200006f, fe_types_pkg::OP_JAL, 0, 0, 0, 32'h20, 8'h58};
    prog[13] = '{8'h58, 32'hfedff36f, fe_types_pkg::OP_JAL, 6, 31, 13, 32'hffffffec, 8'h44};
    prog[14] = '{8'h44, 32'hfff00593, fe_types_pkg::OP_ALU_IMM, 11, 0, 31, 32'hffffffff, 8'h48};
  endtask

  initial begin
    #(WD_CYCLES * CLK_PERIOD);
    $display("watchdog timeout, the expected instruction sequence never completed");
    $display("tests failed");
    $fatal(1, "run did not finish in time");
  end

  initial begin
    void'($urandom(SEED));
    i_rst_n           = 1'b0;
    i_out_allowin     = 1'b0;
    i_inst_sram_rdata = '0;
    held              = 1'b0;
    held_out          = '0;
    load_program();

    // expected output order, walked by next pc
    idx = find_row(RESET_PC);
    while (idx >= 0 && exp_q.size() < N_ROWS) begin
      exp_q.push_back(idx);
      idx = find_row(RESET_PC + 32'(prog[idx].nxt));
    end

    repeat (16) @(negedge i_clk);
    check("o_inst_sram_ren", o_inst_sram_ren, 1'b1);
    check("o_inst_sram_addr", o_inst_sram_addr, RESET_PC);  // first read after release
    i_rst_n = 1'b1;

    while (exp_q.size() > 0) begin
      @(negedge i_clk);
      if (held) begin
        check("o_out_valid", o_out_valid, 1'b1);
        check("o_out", o_out, held_out);
      end
      // allowin for the coming rising edge
      i_out_allowin = ($urandom % 3) != 0;
      held = 1'b0;
      if (o_out_valid && i_out_allowin) begin
        compare_out(exp_q.pop_front());  // accepted at the next rising edge
      end else if (o_out_valid) begin
        held     = 1'b1;
        held_out = o_out;
      end
    end

    @(negedge i_clk);
    if (dut.u_props.fail_cnt == 0) begin
      $display("all tests passed");
      $finish;
    end else begin
      $display("%0d assertion failures in the bound properties", dut.u_props.fail_cnt);
      $display("tests failed");
      $fatal(1, "property checks failed");
    end
  end

endmodule

/* files.f */
verilog/fe_cfg_pkg.sv
verilog/fe_types_pkg.sv
verilog/pc_gen.sv
verilog/if_stage.sv
verilog/inst_decode.sv
verilog/id_stage.sv
verilog/frontend_top.sv
verif/frontend_props.sv
verif/tb_frontend.sv
